/* project.f */
src/dt_cfg_pkg.sv
src/dt_format_pkg.sv
src/dt_ram.sv
src/dt_decode.sv
src/dt_execute.sv
src/dt_result.sv
src/dt_pe_top.sv
verif/dt_pe_props.sv
verif/dt_pe_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the element and its testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dt_pe_tb \
	-f project.f -o dt_pe_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/dt_pe_sim > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* src/dt_cfg_pkg.sv */
/*
 * sizing constants of the decision-tree element
 * data line width, memory address widths, tree slots,
 * input fill margin and tuple queue depth
 */
package dt_cfg_pkg;

	// one input line, tuple features or tree node
	localparam int LINE_BITS = 64;

	// tree memory, 1024 nodes
	localparam int TREE_ADDR_BITS = 10;

	// feature memory, 512 lines used as a ring
	localparam int FEAT_ADDR_BITS = 9;

	// tree slots and the width of a tree id
	localparam int MAX_TREES = 8;
	localparam int TREE_ID_BITS = 3;

	// free lines kept in the ring while ready is high
	localparam int FILL_MARGIN = 4;

	// tuples that may wait for evaluation
	localparam int PENDING_MAX = 3;

endpackage

/* src/dt_decode.sv */
`timescale 1ns/10ps
/*
 * input decode of the decision-tree element
 * control word, tree programming, feature ring writes,
 * fill accounting, input ready and tree instruction issue
 */
module dt_decode #(
	parameter int TREE_ADDR_BITS = dt_cfg_pkg::TREE_ADDR_BITS,
	parameter int FEAT_ADDR_BITS = dt_cfg_pkg::FEAT_ADDR_BITS
) (
	input  logic clk,
	input  logic rst_n,
	input  dt_format_pkg::line_t data_line,
	input  logic data_valid,
	input  logic data_prog,
	input  logic data_ctrl,
	input  logic data_last,
	output logic data_ready,
	output logic tree_we,
	output logic [TREE_ADDR_BITS-1:0] tree_waddr,
	output dt_format_pkg::node_t tree_wdata,
	output logic feat_we,
	output logic [FEAT_ADDR_BITS-1:0] feat_waddr,
	output dt_format_pkg::line_t feat_wdata,
	output dt_format_pkg::tree_instr_t instr,
	output logic instr_valid,
	input  logic instr_ready,
	input  logic leaf_valid,
	input  logic leaf_last
);

	localparam int ID_BITS = dt_cfg_pkg::TREE_ID_BITS;
	localparam int PEND_BITS = $clog2(dt_cfg_pkg::PENDING_MAX + 1);
	localparam int FILL_LIMIT = (1 << FEAT_ADDR_BITS) - dt_cfg_pkg::FILL_MARGIN;

	dt_format_pkg::ctrl_t ctrl_word;
	logic [ID_BITS-1:0] num_trees_m1;
	logic [FEAT_ADDR_BITS-1:0] lines_per_tuple;

	logic [TREE_ADDR_BITS-1:0] tree_prog_addr;
	logic [TREE_ADDR_BITS-1:0] tree_offsets [0:dt_cfg_pkg::MAX_TREES-1];
	logic [ID_BITS:0] trees_programmed;

	logic [FEAT_ADDR_BITS-1:0] feat_wr_addr;
	logic [FEAT_ADDR_BITS:0] fill_cnt;
	logic [FEAT_ADDR_BITS:0] fill_nxt;
	logic retire;

	logic [PEND_BITS-1:0] pending_cnt;
	logic [PEND_BITS-1:0] pending_nxt;
	logic enqueue;
	logic dequeue;
	logic issue;
	logic last_id;

	logic [ID_BITS-1:0] tree_id;
	logic [FEAT_ADDR_BITS-1:0] tuple_base;

	//////////////////////////////////////////////////
	// control word and tree programming
	//////////////////////////////////////////////////

	assign ctrl_word = dt_format_pkg::ctrl_t'(data_line);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			num_trees_m1 <= '0;
			lines_per_tuple <= '0;
		end else if (data_ctrl) begin
			num_trees_m1 <= ctrl_word.num_trees_m1;
			lines_per_tuple <= ctrl_word.lines_per_tuple;
		end
	end

	// tree lines go straight into the tree memory
	assign tree_we = data_prog;
	assign tree_waddr = tree_prog_addr;
	assign tree_wdata = dt_format_pkg::node_t'(data_line);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tree_prog_addr <= '0;
			trees_programmed <= '0;
			for (int i = 0; i < dt_cfg_pkg::MAX_TREES; i++) begin
				tree_offsets[i] <= '0;
			end
		end else if (data_prog) begin
			tree_prog_addr <= tree_prog_addr + 1'b1;
			if (data_last) begin
				// next tree starts right after this line
				if (trees_programmed < dt_cfg_pkg::MAX_TREES - 1) begin
					tree_offsets[trees_programmed[ID_BITS-1:0] + 1'b1] <= tree_prog_addr + 1'b1;
				end
				if (trees_programmed < dt_cfg_pkg::MAX_TREES) begin
					trees_programmed <= trees_programmed + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// feature ring, fill count and input ready
	//////////////////////////////////////////////////

	assign feat_we = data_valid;
	assign feat_waddr = feat_wr_addr;
	assign feat_wdata = data_line;

	// a tuple frees its lines once its last leaf is out
	assign retire = leaf_valid && leaf_last;
	assign fill_nxt = fill_cnt + (FEAT_ADDR_BITS + 1)'(data_valid)
		- (retire ? {1'b0, lines_per_tuple} : '0);

	assign enqueue = data_valid && data_last;
	assign pending_nxt = pending_cnt + PEND_BITS'(enqueue) - PEND_BITS'(dequeue);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			feat_wr_addr <= '0;
			fill_cnt <= '0;
			pending_cnt <= '0;
			data_ready <= 1'b0;
		end else begin
			// address wraps around the ring
			if (data_valid) begin
				feat_wr_addr <= feat_wr_addr + 1'b1;
			end
			fill_cnt <= fill_nxt;
			pending_cnt <= pending_nxt;
			// judged on next state so a one-line tuple cannot overrun the queue
			data_ready <= (pending_nxt < dt_cfg_pkg::PENDING_MAX) && (fill_nxt < FILL_LIMIT);
		end
	end

	//////////////////////////////////////////////////
	// tree instruction issue
	//////////////////////////////////////////////////

	assign instr_valid = (pending_cnt != '0);
	assign issue = instr_valid && instr_ready;
	assign last_id = (tree_id == num_trees_m1);
	assign dequeue = issue && last_id;

	assign instr.tree_base = tree_offsets[tree_id];
	assign instr.tuple_base = tuple_base;
	assign instr.last_tree = last_id;
	// slot beyond the trees received so far
	assign instr.empty_tree = ({1'b0, tree_id} >= trees_programmed);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tree_id <= '0;
			tuple_base <= '0;
		end else if (issue) begin
			tree_id <= last_id ? '0 : tree_id + 1'b1;
			if (last_id) begin
				tuple_base <= tuple_base + lines_per_tuple;
			end
		end
	end

endmodule

/* src/dt_execute.sv */
`timescale 1ns/10ps
/*
 * tree walker, one tree instruction at a time
 * node fetch, feature fetch and branch decision per internal node
 * empty trees return a zero leaf without touching memory
 */
module dt_execute #(
	parameter int TREE_ADDR_BITS = dt_cfg_pkg::TREE_ADDR_BITS,
	parameter int FEAT_ADDR_BITS = dt_cfg_pkg::FEAT_ADDR_BITS
) (
	input  logic clk,
	input  logic rst_n,
	input  dt_format_pkg::tree_instr_t instr,
	input  logic instr_valid,
	output logic instr_ready,
	output logic tree_re,
	output logic [TREE_ADDR_BITS-1:0] tree_raddr,
	input  dt_format_pkg::node_t tree_rdata,
	output logic feat_re,
	output logic [FEAT_ADDR_BITS-1:0] feat_raddr,
	input  dt_format_pkg::line_t feat_rdata,
	output dt_format_pkg::score_t leaf,
	output logic leaf_valid,
	output logic leaf_last
);

	// NODE reads the node, FEAT reads its feature, DECIDE picks the child
	typedef enum logic [1:0] {
		S_IDLE,
		S_NODE,
		S_FEAT,
		S_DECIDE
	} state_t;

	state_t state;
	logic take;

	logic [TREE_ADDR_BITS-1:0] tree_base_r;
	logic [TREE_ADDR_BITS-1:0] node_off;
	logic [FEAT_ADDR_BITS-1:0] tuple_base_r;
	dt_format_pkg::node_t node_r;

	logic [31:0] feature;
	logic go_left;

	assign instr_ready = (state == S_IDLE);
	assign take = instr_valid && instr_ready;

	// memory reads
	assign tree_re = (state == S_NODE);
	assign tree_raddr = tree_base_r + node_off;
	// node word sits on the read port during FEAT
	// a leaf reads no feature
	assign feat_re = (state == S_FEAT) && !tree_rdata.is_leaf;
	assign feat_raddr = tuple_base_r + FEAT_ADDR_BITS'(tree_rdata.findex[7:1]);

	// odd index lives in the upper half of the line
	assign feature = node_r.findex[0] ? feat_rdata[63:32] : feat_rdata[31:0];
	assign go_left = (feature < node_r.value);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			leaf_valid <= 1'b0;
		end else begin
			leaf_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (take) begin
						if (instr.empty_tree) begin
							leaf_valid <= 1'b1;
						end else begin
							state <= S_NODE;
						end
					end
				end
				S_NODE: state <= S_FEAT;
				S_FEAT: begin
					if (tree_rdata.is_leaf) begin
						leaf_valid <= 1'b1;
						state <= S_IDLE;
					end else begin
						state <= S_DECIDE;
					end
				end
				S_DECIDE: state <= S_NODE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// walk context and leaf payload
	always_ff @(posedge clk) begin
		if (take) begin
			tree_base_r <= instr.tree_base;
			tuple_base_r <= instr.tuple_base;
			node_off <= '0;
			// zero leaf for an empty slot
			// a real walk overwrites it
			leaf <= '0;
			leaf_last <= instr.last_tree;
		end
		if (state == S_FEAT) begin
			node_r <= tree_rdata;
			if (tree_rdata.is_leaf) begin
				leaf <= tree_rdata.value;
			end
		end
		if (state == S_DECIDE) begin
			node_off <= go_left ? node_off + 1'b1
				: node_off + node_r.right_offset[TREE_ADDR_BITS-1:0];
		end
	end

endmodule

/* src/dt_format_pkg.sv */
/*
 * bit formats of the decision-tree element
 * input line, tree node, control word,
 * tree instruction and tuple score
 */
package dt_format_pkg;

	// two 32-bit features per line, low half holds the even index
	typedef logic [dt_cfg_pkg::LINE_BITS-1:0] line_t;

	// tree node, left child sits right after its parent
	typedef struct packed {
		// threshold on internal nodes, leaf value on leaves
		logic [31:0] value;
		// distance from this node to its right child
		logic [15:0] right_offset;
		logic [7:0] findex;
		logic is_leaf;
		logic [6:0] spare;
	} node_t;

	// control word, fields at fixed bit positions of the line
	typedef struct packed {
		logic [38:0] rsvd_hi;
		// bits 24..16
		logic [8:0] lines_per_tuple;
		logic [12:0] rsvd_mid;
		// bits 2..0
		logic [2:0] num_trees_m1;
	} ctrl_t;

	// one tree applied to one tuple
	typedef struct packed {
		logic [dt_cfg_pkg::TREE_ADDR_BITS-1:0] tree_base;
		logic [dt_cfg_pkg::FEAT_ADDR_BITS-1:0] tuple_base;
		// final tree of the tuple
		logic last_tree;
		// slot never programmed, leaf is zero
		logic empty_tree;
	} tree_instr_t;

	// score of a tuple, wraps at 32 bits
	typedef logic [31:0] score_t;

endpackage

/* src/dt_pe_top.sv */
`timescale 1ns/10ps
/*
 * decision-tree processing element
 * decode, tree walker, result stage,
 * tree memory and feature memory
 */
module dt_pe_top #(
	parameter int TREE_ADDR_BITS = dt_cfg_pkg::TREE_ADDR_BITS,
	parameter int FEAT_ADDR_BITS = dt_cfg_pkg::FEAT_ADDR_BITS
) (
	input  logic clk,
	input  logic rst_n,
	input  dt_format_pkg::line_t data_line,
	input  logic data_valid,
	input  logic data_prog,
	input  logic data_ctrl,
	input  logic data_last,
	output logic data_ready,
	output dt_format_pkg::score_t score,
	output logic score_valid
);

	// tree memory
	logic tree_we;
	logic [TREE_ADDR_BITS-1:0] tree_waddr;
	dt_format_pkg::node_t tree_wdata;
	logic tree_re;
	logic [TREE_ADDR_BITS-1:0] tree_raddr;
	dt_format_pkg::node_t tree_rdata;

	// feature memory
	logic feat_we;
	logic [FEAT_ADDR_BITS-1:0] feat_waddr;
	dt_format_pkg::line_t feat_wdata;
	logic feat_re;
	logic [FEAT_ADDR_BITS-1:0] feat_raddr;
	dt_format_pkg::line_t feat_rdata;

	// decode to walker, walker to result
	dt_format_pkg::tree_instr_t instr;
	logic instr_valid;
	logic instr_ready;
	dt_format_pkg::score_t leaf;
	logic leaf_valid;
	logic leaf_last;

	dt_decode #(
		.TREE_ADDR_BITS(TREE_ADDR_BITS),
		.FEAT_ADDR_BITS(FEAT_ADDR_BITS)
	) i_decode (
		.clk(clk), .rst_n(rst_n),
		.data_line(data_line), .data_valid(data_valid), .data_prog(data_prog),
		.data_ctrl(data_ctrl), .data_last(data_last), .data_ready(data_ready),
		.tree_we(tree_we), .tree_waddr(tree_waddr), .tree_wdata(tree_wdata),
		.feat_we(feat_we), .feat_waddr(feat_waddr), .feat_wdata(feat_wdata),
		.instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready),
		.leaf_valid(leaf_valid), .leaf_last(leaf_last)
	);

	dt_execute #(
		.TREE_ADDR_BITS(TREE_ADDR_BITS),
		.FEAT_ADDR_BITS(FEAT_ADDR_BITS)
	) i_execute (
		.clk(clk), .rst_n(rst_n),
		.instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready),
		.tree_re(tree_re), .tree_raddr(tree_raddr), .tree_rdata(tree_rdata),
		.feat_re(feat_re), .feat_raddr(feat_raddr), .feat_rdata(feat_rdata),
		.leaf(leaf), .leaf_valid(leaf_valid), .leaf_last(leaf_last)
	);

	dt_result i_result (
		.clk(clk), .rst_n(rst_n),
		.leaf(leaf), .leaf_valid(leaf_valid), .leaf_last(leaf_last),
		.score(score), .score_valid(score_valid)
	);

	dt_ram #(
		.ADDR_BITS(TREE_ADDR_BITS),
		.word_t(dt_format_pkg::node_t)
	) tree_mem (
		.clk(clk), .we(tree_we), .waddr(tree_waddr), .wdata(tree_wdata),
		.re(tree_re), .raddr(tree_raddr), .rdata(tree_rdata)
	);

	dt_ram #(
		.ADDR_BITS(FEAT_ADDR_BITS),
		.word_t(dt_format_pkg::line_t)
	) feat_mem (
		.clk(clk), .we(feat_we), .waddr(feat_waddr), .wdata(feat_wdata),
		.re(feat_re), .raddr(feat_raddr), .rdata(feat_rdata)
	);

endmodule

/* src/dt_ram.sv */
`timescale 1ns/10ps
/*
 * simple dual port memory
 * one write port, one registered read port
 * word type set per instance
 */
module dt_ram #(
	parameter int ADDR_BITS = 10,
	parameter type word_t = logic [63:0]
) (
	input  logic clk,
	input  logic we,
	input  logic [ADDR_BITS-1:0] waddr,
	input  word_t wdata,
	input  logic re,
	input  logic [ADDR_BITS-1:0] raddr,
	output word_t rdata
);

	localparam int DEPTH = 1 << ADDR_BITS;

	word_t mem [0:DEPTH-1];

	// write side
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read data follows the enable by one cycle
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[raddr];
		end
	end

endmodule

/* src/dt_result.sv */
`timescale 1ns/10ps
/*
 * result stage
 * sums the leaves of a tuple and emits the score
 */
module dt_result (
	input  logic clk,
	input  logic rst_n,
	input  dt_format_pkg::score_t leaf,
	input  logic leaf_valid,
	input  logic leaf_last,
	output dt_format_pkg::score_t score,
	output logic score_valid
);

	// running sum of the leaves seen for the current tuple
	dt_format_pkg::score_t acc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
			score_valid <= 1'b0;
		end else begin
			score_valid <= 1'b0;
			if (leaf_valid) begin
				if (leaf_last) begin
					// tuple complete, start over for the next one
					acc <= '0;
					score_valid <= 1'b1;
				end else begin
					acc <= acc + leaf;
				end
			end
		end
	end

	// score register, sum wraps at 32 bits
	always_ff @(posedge clk) begin
		if (leaf_valid && leaf_last) begin
			score <= acc + leaf;
		end
	end

endmodule

/* verif/dt_pe_props.sv */
`timescale 1ns/10ps
/*
 * concurrent assertions on the element's top-level ports
 * reset behaviour of ready and score strobe, known score strobe
 */
module dt_pe_props (
	input logic clk,
	input logic rst_n,
	input logic data_ready,
	input logic score_valid
);

	// number of failed assertions
	int fail_count = 0;

	// pipeline is empty right after reset, so no score can follow
	a_no_score_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !score_valid)
		else begin
			$error("score_valid high in the cycle after reset release");
			fail_count++;
		end

	// input must not look ready while reset is held
	a_ready_low_in_reset: assert property (@(posedge clk) !rst_n |=> !data_ready)
		else begin
			$error("data_ready high while reset is held");
			fail_count++;
		end

	a_score_valid_known: assert property (@(posedge clk) rst_n |-> !$isunknown(score_valid))
		else begin
			$error("score_valid is unknown");
			fail_count++;
		end

endmodule

bind dt_pe_top dt_pe_props i_props (
	.clk(clk),
	.rst_n(rst_n),
	.data_ready(data_ready),
	.score_valid(score_valid)
);

/* verif/dt_pe_tb.sv */
`timescale 1ns/10ps
/*
 * testbench of the decision-tree element
 * tree and tuple generation, reference scoring,
 * score compare process and final report
 */
module dt_pe_tb;

	localparam int WAIT_LIMIT = 2000;
	// line kinds on the input bus
	localparam int TUPLE = 0;
	localparam int PROG = 1;
	localparam int CTRL = 2;

	logic clk;
	logic rst_n;
	dt_format_pkg::line_t data_line;
	logic data_valid;
	logic data_prog;
	logic data_ctrl;
	logic data_last;
	logic data_ready;
	dt_format_pkg::score_t score;
	logic score_valid;

	integer seed = 40599;
	int value_errors;
	int protocol_errors;

	// own copy of the trees, preorder with the left child right after its parent
	dt_format_pkg::node_t trees [0:dt_cfg_pkg::MAX_TREES-1][0:31];
	int n_prog;
	int n_trees_m1;
	int lpt;
	dt_format_pkg::line_t tuple [0:15];
	dt_format_pkg::score_t expected [$];

	dt_pe_top i_dut (
		.clk(clk), .rst_n(rst_n),
		.data_line(data_line), .data_valid(data_valid), .data_prog(data_prog),
		.data_ctrl(data_ctrl), .data_last(data_last), .data_ready(data_ready),
		.score(score), .score_valid(score_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// reference model and compare
	//////////////////////////////////////////////////

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	// walk every configured slot, unprogrammed ones add nothing
	function automatic dt_format_pkg::score_t ref_score();
		dt_format_pkg::score_t sum;
		dt_format_pkg::node_t nd;
		dt_format_pkg::line_t ln;
		logic [31:0] feat;
		int idx;
		sum = '0;
		for (int t = 0; t <= n_trees_m1; t++) begin
			if (t < n_prog) begin
				idx = 0;
				nd = trees[t][0];
				while (!nd.is_leaf) begin
					ln = tuple[nd.findex >> 1];
					feat = nd.findex[0] ? ln[63:32] : ln[31:0];
					idx = (feat < nd.value) ? idx + 1 : idx + int'(nd.right_offset);
					nd = trees[t][idx];
				end
				sum = sum + nd.value;
			end
		end
		return sum;
	endfunction

	task automatic check_score(input string name, input dt_format_pkg::score_t actual,
		input dt_format_pkg::score_t exp);
		if (actual !== exp) begin
			value_errors++;
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, exp);
		end
	endtask

	task automatic check_level(input string name, input logic actual, input logic exp);
		if (actual !== exp) begin
			value_errors++;
			$display("FAIL %s: got 0x%1h, expected 0x%1h", name, actual, exp);
		end
	endtask

	// one expected score per pulse, in tuple order
	always @(negedge clk) begin
		if (rst_n && score_valid) begin
			if (expected.size() == 0) begin
				protocol_errors++;
				$display("ERROR: score_valid pulse while no tuple is outstanding");
			end else begin
				check_score("score", score, expected.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (!data_ready && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (!data_ready) begin
			protocol_errors++;
			$display("ERROR: data_ready stayed low past the timeout");
		end
	endtask

	task automatic drive_line(input int kind, input dt_format_pkg::line_t line, input logic last);
		if (kind == TUPLE) begin
			wait_ready();
		end
		@(posedge clk);
		data_line <= line;
		data_valid <= (kind == TUPLE);
		data_prog <= (kind == PROG);
		data_ctrl <= (kind == CTRL);
		data_last <= last;
	endtask

	task automatic idle();
		@(posedge clk);
		data_valid <= 1'b0;
		data_prog <= 1'b0;
		data_ctrl <= 1'b0;
		data_last <= 1'b0;
	endtask

	// reset held 4 cycles, ready expected one cycle after release
	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		n_prog = 0;
		@(negedge clk);
		check_level("score_valid", score_valid, 1'b0);
		check_level("data_ready", data_ready, 1'b0);
		@(negedge clk);
		check_level("data_ready", data_ready, 1'b1);
	endtask

	task automatic write_ctrl(input int ntm1, input int lines);
		dt_format_pkg::ctrl_t c;
		c = '0;
		c.num_trees_m1 = 3'(ntm1);
		c.lines_per_tuple = 9'(lines);
		n_trees_m1 = ntm1;
		lpt = lines;
		drive_line(CTRL, dt_format_pkg::line_t'(c), 1'b0);
		idle();
	endtask

	// full tree of the given depth, sent in preorder
	task automatic add_tree(input int depth);
		int stack [$];
		int k;
		int pos;
		dt_format_pkg::node_t nd;
		pos = 0;
		stack.push_back(depth);
		while (stack.size() > 0) begin
			k = stack.pop_back();
			nd = '0;
			nd.value = $random(seed);
			if (k == 0) begin
				nd.is_leaf = 1'b1;
			end else begin
				// left subtree holds 2^k - 1 nodes
				nd.right_offset = 16'(1 << k);
				nd.findex = 8'(rand_below(2 * lpt));
				stack.push_back(k - 1);
				stack.push_back(k - 1);
			end
			trees[n_prog][pos] = nd;
			drive_line(PROG, dt_format_pkg::line_t'(nd), stack.size() == 0);
			pos++;
		end
		n_prog++;
		idle();
	endtask

	task automatic send_tuples(input int count);
		for (int n = 0; n < count; n++) begin
			for (int i = 0; i < lpt; i++) begin
				tuple[i] = {$random(seed), $random(seed)};
			end
			expected.push_back(ref_score());
			for (int i = 0; i < lpt; i++) begin
				drive_line(TUPLE, tuple[i], i == lpt - 1);
			end
			// gap after the last line so ready reflects the new pending count
			idle();
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (expected.size() > 0 && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (expected.size() > 0) begin
			protocol_errors++;
			$display("ERROR: %0d scores never came out", expected.size());
			expected.delete();
		end
	endtask

	initial begin
		rst_n = 1'b0;
		data_line = '0;
		data_valid = 1'b0;
		data_prog = 1'b0;
		data_ctrl = 1'b0;
		data_last = 1'b0;
		value_errors = 0;
		protocol_errors = 0;
		n_prog = 0;
		n_trees_m1 = 0;
		lpt = 1;

		// single tree of depth three
		apply_reset();
		write_ctrl(0, 2);
		add_tree(3);
		send_tuples(20);
		wait_drain();

		// four trees of different sizes, one a bare leaf
		apply_reset();
		write_ctrl(3, 3);
		add_tree(0);
		add_tree(1);
		add_tree(2);
		add_tree(4);
		send_tuples(20);
		wait_drain();

		// six slots, three programmed
		apply_reset();
		write_ctrl(5, 2);
		add_tree(2);
		add_tree(1);
		add_tree(3);
		send_tuples(10);
		wait_drain();

		// long stream throttled by data_ready
		apply_reset();
		write_ctrl(1, 2);
		add_tree(3);
		add_tree(2);
		send_tuples(60);
		wait_drain();

		// new tuple layout, same trees
		write_ctrl(1, 3);
		send_tuples(20);
		wait_drain();

		// window for stray score pulses
		repeat (20) @(negedge clk);

		$display("errors: value %0d, protocol %0d, assertion %0d",
			value_errors, protocol_errors, i_dut.i_props.fail_count);
		if (value_errors + protocol_errors + i_dut.i_props.fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
